// ==== Bender.yml ====
package:
  name: caches

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_types_pkg.sv
      - src/icache.sv
      - src/memory_control.sv
      - src/ram.sv
      - src/caches_top.sv
      - target: simulation
        files:
          - sim/icache_chk.sv
          - sim/caches_tb.sv

// ==== sim.f ====
+incdir+src
src/cpu_types_pkg.sv
src/icache.sv
src/memory_control.sv
src/ram.sv
src/caches_top.sv
sim/icache_chk.sv
sim/caches_tb.sv

// ==== sim/caches_tb.sv ====
`default_nettype none

`include "cache_macros.svh"

module caches_tb
  import cpu_types_pkg::*;
();

  localparam int PERIOD  = 40;
  localparam int DRV_DLY = 2;
  localparam int N_LOAD  = 64;
  localparam int N_FRESH = 16;
  localparam int N_PAIRS = 4;
  localparam int N_HALF  = 200;
  // load, fresh, conflict, stale and mixed accesses
  localparam int N_OPS = 2*N_LOAD + 2*N_FRESH + 6*N_PAIRS + 8 + 2*N_HALF;
  // worst case per access plus a reset margin
  localparam int WD_CYCLES = N_OPS * (2*`RAM_LAT + 4) + 8;

  logic  CLK = 1'b0;
  logic  nRST = 1'b0;
  logic  imem_ren = 1'b0;
  word_t imem_addr = '0;
  logic  ihit;
  word_t imem_load;
  logic  dmem_ren = 1'b0;
  logic  dmem_wen = 1'b0;
  word_t dmem_addr = '0;
  word_t dmem_store = '0;
  logic  dmem_wait;
  word_t dmem_load;

  // reference memory and cache
  word_t         mem_model [2**`RAM_ADDR_W];
  icache_frame_t cache_model [`ICACHE_FRAMES] = '{default: '0};
  // addresses written during program load
  word_t         pool [N_LOAD];
  word_t         mix_sel [2*N_HALF];
  word_t         rng_state = 32'ha247_e2ac;

  caches_top dut_i (.*);

  // handshake assertions inside the cache
  bind icache icache_chk icache_chk_i (.*);

  always #(PERIOD/2) CLK = ~CLK;

  // lcg step
  function automatic word_t next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t got);
    if (exp !== got) begin
      $display("ERROR %s expected %h got %h", name, exp, got);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // one data port access
  // memory model follows a write once it has committed
  task automatic data_access(input logic wr, input word_t addr, input word_t wdata,
                             input logic exact);
    int    cycles;
    word_t got;
    cycles = 0;
    dmem_ren = !wr;
    dmem_wen = wr;
    dmem_addr = addr;
    dmem_store = wdata;
    do begin
      @(negedge CLK);
      cycles++;
      got = dmem_load;
    end while (dmem_wait);
    @(posedge CLK);
    #DRV_DLY;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    if (exact) begin
      check_value("dmem_wait latency", `RAM_LAT, cycles);
    end
    if (wr) begin
      mem_model[addr[`RAM_ADDR_W+1:2]] = wdata;
    end else begin
      check_value("dmem_load", mem_model[addr[`RAM_ADDR_W+1:2]], got);
    end
  endtask

  // fetch one word and predict it with the direct-mapped model
  task automatic fetch_check(input word_t addr, input logic exact, output word_t got);
    icache_addr_u a;
    word_t        fill_w;
    int           cycles;
    a.raw = addr;
    cycles = 0;
    imem_ren = 1'b1;
    imem_addr = addr;
    do begin
      @(negedge CLK);
      cycles++;
      got = imem_load;
      // memory word as the refill saw it
      fill_w = mem_model[addr[`RAM_ADDR_W+1:2]];
    end while (!ihit);
    @(posedge CLK);
    #DRV_DLY;
    imem_ren = 1'b0;
    if (cache_model[a.f.idx].valid && cache_model[a.f.idx].tag == a.f.tag) begin
      check_value("imem_load", cache_model[a.f.idx].data, got);
      // hit is combinational so it lands in the first cycle
      check_value("ihit hit latency", 1, cycles);
    end else begin
      check_value("imem_load", fill_w, got);
      if (exact) begin
        check_value("ihit miss latency", `RAM_LAT + 2, cycles);
      end
      cache_model[a.f.idx] = '{valid: 1'b1, tag: a.f.tag, data: fill_w};
    end
    // idle cycle so the next fetch raises imem_ren again
    @(posedge CLK);
    #DRV_DLY;
  endtask

  // watchdog
  initial begin
    #(WD_CYCLES * PERIOD);
    $display("timeout: an access did not complete in the expected time");
    $display("Regression failed");
    $fatal(1);
  end

  // first checker failure ends the run
  initial begin
    wait (dut_i.icache_i.icache_chk_i.fail_count != 0);
    $display("icache_chk flagged a handshake violation");
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    word_t a;
    word_t b;
    word_t old_w;
    word_t got;
    repeat (3) @(posedge CLK);
    #DRV_DLY;
    nRST = 1'b1;
    // program load then read every word back
    for (int i = 0; i < N_LOAD; i++) begin
      pool[i] = next_random() & 32'h0000_0ffc;
      data_access(1'b1, pool[i], next_random(), 1'b1);
    end
    for (int i = 0; i < N_LOAD; i++) begin
      data_access(1'b0, pool[i], '0, 1'b1);
    end
    // miss then the repeat hits in its first cycle
    for (int i = 0; i < N_FRESH; i++) begin
      fetch_check(pool[i], 1'b1, old_w);
      fetch_check(pool[i], 1'b1, got);
      check_value("imem_load repeat", old_w, got);
    end
    // same index and other tag so each fetch evicts the other
    for (int p = 0; p < N_PAIRS; p++) begin
      a = next_random() & 32'h0000_0ffc;
      b = a ^ ((next_random() % 63 + 1) << 6);
      data_access(1'b1, a, next_random(), 1'b1);
      data_access(1'b1, b, next_random(), 1'b1);
      repeat (2) begin
        fetch_check(a, 1'b1, got);
        fetch_check(b, 1'b1, got);
      end
    end
    // data write leaves the cached copy stale until eviction
    a = pool[0];
    b = a ^ 32'h0000_0040;
    fetch_check(a, 1'b1, old_w);
    data_access(1'b1, a, ~old_w, 1'b1);
    fetch_check(a, 1'b1, got);
    check_value("stale imem_load", old_w, got);
    data_access(1'b1, b, next_random(), 1'b1);
    fetch_check(b, 1'b1, got);
    fetch_check(a, 1'b1, got);
    check_value("refreshed imem_load", ~old_w, got);
    // both ports at once with stimulus drawn up front
    for (int i = 0; i < 2*N_HALF; i++) begin
      mix_sel[i] = next_random();
    end
    fork
      for (int i = 0; i < N_HALF; i++) begin
        fetch_check(pool[mix_sel[i] % N_LOAD], 1'b0, a);
      end
      for (int i = N_HALF; i < 2*N_HALF; i++) begin
        // idle gap lets a waiting refill take the ram
        repeat (1 + mix_sel[i][31]) @(posedge CLK);
        #DRV_DLY;
        data_access(mix_sel[i][30], pool[mix_sel[i] % N_LOAD],
                    mix_sel[i] * 32'd2654435761, 1'b0);
      end
    join
    if (dut_i.icache_i.icache_chk_i.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("icache_chk flagged a handshake violation");
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== sim/icache_chk.sv ====
`default_nettype none

module icache_chk
  import cpu_types_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  imem_ren,
  input word_t imem_addr,
  input logic  ihit,
  input logic  iren,
  input word_t iaddr,
  input logic  iwait
);

  // failed assertions so far
  int unsigned fail_count = 0;

  // refill request drops only after a completing cycle
  iren_release: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(iren) |-> $past(!iwait))
    else begin
      $error("iren fell without a cycle of iwait low");
      fail_count++;
    end

  // no hit while a refill is outstanding
  hit_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(ihit && iren))
    else begin
      $error("ihit and iren high together");
      fail_count++;
    end

  // refill address held while memory stalls
  iaddr_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (iren && iwait) |=> $stable(iaddr))
    else begin
      $error("iaddr changed during a stalled refill");
      fail_count++;
    end

  // held fetch hits right after the fill
  fill_hit: assert property (@(posedge CLK) disable iff (!nRST)
    (iren && !iwait) ##1 (imem_ren && $stable(imem_addr)) |-> ihit)
    else begin
      $error("no hit in the cycle after a fill");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== src/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// width of one memory word and of every address
`define WORD_W 32

// direct-mapped instruction cache geometry
`define ICACHE_FRAMES 16

// index bits select one of the frames
`define IDX_W 4

// tag is what is left after index and byte offset
`define TAG_W 26

// word-address bits of the ram model, upper address bits ignored
`define RAM_ADDR_W 10

// cycles a request is held before ram_wait drops
// must be at least 1
`define RAM_LAT 3

`endif

// ==== src/caches_top.sv ====
`default_nettype none

module caches_top
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // instruction fetch port
  input  logic  imem_ren,
  input  word_t imem_addr,
  output logic  ihit,
  output word_t imem_load,
  // data port, has priority at the ram
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  output logic  dmem_wait,
  output word_t dmem_load
);

  // refill path, cache to controller
  logic  iren;
  word_t iaddr;
  logic  iwait;
  word_t iload;

  // controller to ram
  logic  ram_ren;
  logic  ram_wen;
  word_t ram_addr;
  word_t ram_store;
  logic  ram_wait;
  word_t ram_load;

  // direct-mapped instruction cache
  icache icache_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .imem_ren  (imem_ren),
    .imem_addr (imem_addr),
    .ihit      (ihit),
    .imem_load (imem_load),
    .iren      (iren),
    .iaddr     (iaddr),
    .iwait     (iwait),
    .iload     (iload)
  );

  // arbiter between refill and data port
  memory_control memory_control_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .iren       (iren),
    .iaddr      (iaddr),
    .iwait      (iwait),
    .iload      (iload),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dmem_wait  (dmem_wait),
    .dmem_load  (dmem_load),
    .ram_ren    (ram_ren),
    .ram_wen    (ram_wen),
    .ram_addr   (ram_addr),
    .ram_store  (ram_store),
    .ram_wait   (ram_wait),
    .ram_load   (ram_load)
  );

  // fixed latency word memory
  ram ram_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_addr  (ram_addr),
    .ram_store (ram_store),
    .ram_wait  (ram_wait),
    .ram_load  (ram_load)
  );

endmodule

`default_nettype wire

// ==== src/cpu_types_pkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package cpu_types_pkg;

  // one machine word, data and address alike
  typedef logic [`WORD_W-1:0] word_t;

  // field view of an instruction address
  // msb first so the layout matches the raw word
  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [`IDX_W-1:0] idx;
    logic [1:0]        bytoff;
  } icachef_t;

  // same address word seen two ways
  // raw goes to memory, fields drive lookup
  typedef union packed {
    word_t    raw;
    icachef_t f;
  } icache_addr_u;

  // one direct-mapped frame
  // valid plus tag plus a single data word
  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    word_t             data;
  } icache_frame_t;

endpackage

`default_nettype wire

// ==== src/icache.sv ====
`default_nettype none

`include "cache_macros.svh"

module icache
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // fetch port held until ihit
  input  logic  imem_ren,
  input  word_t imem_addr,
  output logic  ihit,
  output word_t imem_load,
  // refill port toward memory_control
  output logic  iren,
  output word_t iaddr,
  input  logic  iwait,
  input  word_t iload
);

  // refill controller states
  typedef enum logic {
    IDLE    = 1'b0,
    REQUEST = 1'b1
  } ic_state_e;

  // frame storage
  icache_frame_t [`ICACHE_FRAMES-1:0] frames;

  // fetch address seen both raw and as fields
  icache_addr_u addr_u;

  // frame picked by the index field
  icache_frame_t sel_frame;

  ic_state_e state;
  ic_state_e state_nxt;

  logic tag_match;
  logic fill_en;

  // decode the fetch address
  assign addr_u.raw = imem_addr;

  // indexed frame lookup
  assign sel_frame = frames[addr_u.f.idx];

  // valid frame whose tag equals the address tag
  assign tag_match = sel_frame.valid && (sel_frame.tag == addr_u.f.tag);

  // frame gets written on the edge where memory answers
  assign fill_en = (state == REQUEST) && !iwait;

  // hit is purely combinational
  // masked during the fill cycle itself
  assign ihit = tag_match && !fill_en;

  // data word straight out of the indexed frame
  assign imem_load = sel_frame.data;

  // refill address is the raw fetch word
  assign iaddr = addr_u.raw;

  // moore output with the refill request only in REQUEST
  assign iren = (state == REQUEST);

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // miss seen this cycle so go fetch next cycle
        if (imem_ren && !tag_match) begin
          state_nxt = REQUEST;
        end
      end
      REQUEST: begin
        // stay until memory drops its wait
        if (!iwait) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // frame array
  // all frames cleared so nothing hits after reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      frames <= '0;
    end else if (fill_en) begin
      // whole frame replaced in one edge
      frames[addr_u.f.idx].valid <= 1'b1;
      frames[addr_u.f.idx].tag   <= addr_u.f.tag;
      frames[addr_u.f.idx].data  <= iload;
    end
  end

endmodule

`default_nettype wire

// ==== src/memory_control.sv ====
`default_nettype none

module memory_control
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // instruction refill side
  input  logic  iren,
  input  word_t iaddr,
  output logic  iwait,
  output word_t iload,
  // external data port
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  output logic  dmem_wait,
  output word_t dmem_load,
  // ram side
  output logic  ram_ren,
  output logic  ram_wen,
  output word_t ram_addr,
  output word_t ram_store,
  input  logic  ram_wait,
  input  word_t ram_load
);

  // owner of the ram, set while an instruction access is running
  // low means the data port
  logic owner_i;
  logic owner_i_nxt;

  // any data request this cycle
  logic dreq;

  // instruction side has the ram this cycle
  logic sel_i;

  assign dreq = dmem_ren || dmem_wen;

  // running instruction access keeps the ram
  // otherwise data first, instruction only when data is idle
  assign sel_i = owner_i || (iren && !dreq);

  // hold ownership while the granted refill still waits
  // cleared on the completing cycle
  assign owner_i_nxt = sel_i && iren && ram_wait;

  // request routing
  assign ram_ren   = sel_i ? iren  : dmem_ren;
  assign ram_wen   = sel_i ? 1'b0  : dmem_wen;
  assign ram_addr  = sel_i ? iaddr : dmem_addr;

  // only the data port ever writes
  assign ram_store = dmem_store;

  // wait goes to the owner, the loser sees wait stuck high
  assign iwait     = sel_i ? ram_wait : 1'b1;
  assign dmem_wait = sel_i ? 1'b1     : ram_wait;

  // read data fans out, each side qualifies it with its own wait
  assign iload     = ram_load;
  assign dmem_load = ram_load;

  // owner register, data port after reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      owner_i <= 1'b0;
    end else begin
      owner_i <= owner_i_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== src/ram.sv ====
`default_nettype none

`include "cache_macros.svh"

module ram
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // request, ren and wen never both
  input  logic  ram_ren,
  input  logic  ram_wen,
  input  word_t ram_addr,
  input  word_t ram_store,
  // low in the completing cycle
  output logic  ram_wait,
  output word_t ram_load
);

  localparam int DEPTH = 2 ** `RAM_ADDR_W;

  // wide enough to hold RAM_LAT
  localparam int CNT_W = $clog2(`RAM_LAT + 1);

  // storage
  word_t mem [DEPTH];

  // word index, byte offset dropped
  // upper address bits ignored
  logic [`RAM_ADDR_W-1:0] widx;

  // held request cycles so far
  logic [CNT_W-1:0] lat_cnt;

  logic req;
  logic done;

  assign widx = ram_addr[`RAM_ADDR_W+1:2];

  assign req = ram_ren || ram_wen;

  // last cycle of the latency window
  assign done = req && (lat_cnt == CNT_W'(`RAM_LAT - 1));

  assign ram_wait = !done;

  // asynchronous read, valid once wait is low
  assign ram_load = mem[widx];

  // latency counter
  // starts on the first request cycle
  // clears on completion or if the request drops
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end else if (done || !req) begin
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  // write commits on the completing edge
  // array contents undefined until loaded
  always_ff @(posedge CLK) begin
    if (ram_wen && done) begin
      mem[widx] <= ram_store;
    end
  end

endmodule

`default_nettype wire
